// ==== vlog.f ====
+incdir+rtl
rtl/mem_bridge_pkg.sv
rtl/bridge_ifs.sv
rtl/axi_lite_slave.sv
rtl/test_reg_file.sv
rtl/fwft_queue.sv
rtl/mem_req_splitter.sv
rtl/mem_cmd_arbiter.sv
rtl/mem_bridge_top.sv
verif/mem_bridge_asserts.sv
verif/mem_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: mem_bridge

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_bridge_pkg.sv
      - rtl/bridge_ifs.sv
      - rtl/axi_lite_slave.sv
      - rtl/test_reg_file.sv
      - rtl/fwft_queue.sv
      - rtl/mem_req_splitter.sv
      - rtl/mem_cmd_arbiter.sv
      - rtl/mem_bridge_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/mem_bridge_asserts.sv
      - verif/mem_bridge_tb.sv

// ==== verif/mem_bridge_tb.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module mem_bridge_tb;

   localparam int OP_LITE_WR = 0;
   localparam int OP_LITE_RD = 1;
   localparam int OP_MEM_WR  = 2;
   localparam int OP_MEM_RD  = 3;
   localparam int OP_STALL   = 4;
   localparam int MAX_ROWS   = 32;
   localparam int ENTRY_W    = 3 + `APP_ADDR_W + `MEM_DATA_W + `MEM_STRB_W;

   logic                    s_axi_aclk;
   logic                    s_axi_aresetn;
   logic [`LITE_ADDR_W-1:0] awaddr;
   logic                    awvalid;
   logic                    awready;
   logic [`LITE_DATA_W-1:0] wdata;
   logic                    wvalid;
   logic                    wready;
   logic                    bready;
   logic                    bvalid;
   logic [1:0]              bresp;
   logic [`LITE_ADDR_W-1:0] araddr;
   logic                    arvalid;
   logic                    arready;
   logic                    rready;
   logic                    rvalid;
   logic [`LITE_DATA_W-1:0] rdata;
   logic [1:0]              rresp;
   logic [`REQ_ADDR_W-1:0]  wr_addr;
   logic [`MEM_DATA_W-1:0]  wr_data;
   logic [`MEM_STRB_W-1:0]  wr_strb;
   logic                    wr_cmd_rdy;
   logic                    rd_en;
   logic [`REQ_ADDR_W-1:0]  rd_addr;
   logic                    rd_cmd_rdy;
   logic                    app_rdy;
   logic                    app_en;
   logic [2:0]              app_cmd;
   logic [`APP_ADDR_W-1:0]  app_addr;
   logic [`MEM_DATA_W-1:0]  app_wdf_data;
   logic [`MEM_STRB_W-1:0]  app_wdf_mask;

   // Stimulus table, one column per array
   int                      op_tab   [MAX_ROWS];
   logic [`REQ_ADDR_W-1:0]  addr_tab [MAX_ROWS];
   logic [`MEM_DATA_W-1:0]  data_tab [MAX_ROWS];
   logic [`MEM_STRB_W-1:0]  strb_tab [MAX_ROWS];
   logic [`LITE_DATA_W-1:0] exp_tab  [MAX_ROWS];
   int                      num_rows;
   integer                  seed;
   int                      cycle_cnt;
   int                      timeout_limit;

   logic [ENTRY_W-1:0] exp_wr [$];
   logic [ENTRY_W-1:0] exp_rd [$];
   logic [ENTRY_W-1:0] got_wr [$];
   logic [ENTRY_W-1:0] got_rd [$];

   mem_bridge_top dut_i (
      .s_axi_aclk         (s_axi_aclk),
      .s_axi_aresetn      (s_axi_aresetn),
      .s_axi_lite_awaddr  (awaddr),
      .s_axi_lite_awvalid (awvalid),
      .s_axi_lite_awready (awready),
      .s_axi_lite_wdata   (wdata),
      .s_axi_lite_wvalid  (wvalid),
      .s_axi_lite_wready  (wready),
      .s_axi_lite_bready  (bready),
      .s_axi_lite_bvalid  (bvalid),
      .s_axi_lite_bresp   (bresp),
      .s_axi_lite_araddr  (araddr),
      .s_axi_lite_arvalid (arvalid),
      .s_axi_lite_arready (arready),
      .s_axi_lite_rready  (rready),
      .s_axi_lite_rvalid  (rvalid),
      .s_axi_lite_rdata   (rdata),
      .s_axi_lite_rresp   (rresp),
      .wr_addr            (wr_addr),
      .wr_data            (wr_data),
      .wr_strb            (wr_strb),
      .wr_cmd_rdy         (wr_cmd_rdy),
      .rd_en              (rd_en),
      .rd_addr            (rd_addr),
      .rd_cmd_rdy         (rd_cmd_rdy),
      .app_rdy            (app_rdy),
      .app_en             (app_en),
      .app_cmd            (app_cmd),
      .app_addr           (app_addr),
      .app_wdf_data       (app_wdf_data),
      .app_wdf_mask       (app_wdf_mask)
   );

   initial begin
      s_axi_aclk = 1'b0;
      forever #4 s_axi_aclk = ~s_axi_aclk;
   end

   ////////////////////
   // Monitor and watchdogs
   ////////////////////
   // Sampled mid-cycle, where inputs and outputs are settled
   always @(negedge s_axi_aclk) begin
      if (s_axi_aresetn && app_en && app_rdy) begin
         if (app_cmd == mem_bridge_pkg::READ) begin
            got_rd.push_back({app_cmd, app_addr, app_wdf_data, app_wdf_mask});
         end else begin
            got_wr.push_back({app_cmd, app_addr, app_wdf_data, app_wdf_mask});
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      wait (timeout_limit != 0);
      while (cycle_cnt < timeout_limit) begin
         @(posedge s_axi_aclk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("TEST FAILED");
      $fatal(1, "Timeout");
   end

   initial begin : assertion_watch
      wait (dut_i.asserts_i.assert_fail_cnt != 0);
      $display("A bound assertion on the DUT failed");
      $display("TEST FAILED");
      $fatal(1, "Assertion failure");
   end

   ////////////////////
   // Helpers
   ////////////////////
   task automatic compare_values(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "Mismatch in %s", name);
      end
   endtask

   function automatic void add_row(input int op, input logic [`REQ_ADDR_W-1:0] addr,
                                   input logic [`MEM_DATA_W-1:0] data,
                                   input logic [`MEM_STRB_W-1:0] strb,
                                   input logic [`LITE_DATA_W-1:0] expected);
      op_tab[num_rows]   = op;
      addr_tab[num_rows] = addr;
      data_tab[num_rows] = data;
      strb_tab[num_rows] = strb;
      exp_tab[num_rows]  = expected;
      num_rows++;
   endfunction

   task automatic next_cycle();
      @(posedge s_axi_aclk);
      #1;
   endtask

   task automatic axi_write(input int row);
      awaddr  = addr_tab[row][`LITE_ADDR_W-1:0];
      wdata   = data_tab[row][`LITE_DATA_W-1:0];
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b0;
      @(negedge s_axi_aclk);
      while (!awready) @(negedge s_axi_aclk);
      compare_values($sformatf("row %0d wready", row), 1'b1, wready);
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      @(negedge s_axi_aclk);
      while (!bvalid) @(negedge s_axi_aclk);
      compare_values($sformatf("row %0d bresp", row), mem_bridge_pkg::OKAY, bresp);
      // Response held back for two cycles
      repeat (2) next_cycle();
      bready = 1'b1;
      next_cycle();
      compare_values($sformatf("row %0d bvalid", row), 1'b0, bvalid);
   endtask

   task automatic axi_read(input int row);
      araddr  = addr_tab[row][`LITE_ADDR_W-1:0];
      arvalid = 1'b1;
      @(negedge s_axi_aclk);
      compare_values($sformatf("row %0d arready", row), 1'b1, arready);
      next_cycle();
      arvalid = 1'b0;
      @(negedge s_axi_aclk);
      while (!rvalid) @(negedge s_axi_aclk);
      compare_values($sformatf("row %0d rdata", row), exp_tab[row], rdata);
      compare_values($sformatf("row %0d rresp", row), mem_bridge_pkg::OKAY, rresp);
      next_cycle();
   endtask

   // Expected command is queued only once the request is accepted
   task automatic request_write(input int row);
      wr_addr = addr_tab[row];
      wr_data = data_tab[row];
      wr_strb = strb_tab[row];
      if (strb_tab[row] != '0) begin
         @(negedge s_axi_aclk);
         while (!wr_cmd_rdy) @(negedge s_axi_aclk);
         exp_wr.push_back({exp_tab[row][2:0], addr_tab[row][`APP_ADDR_LSB +: `APP_ADDR_W],
                           data_tab[row], ~strb_tab[row]});
      end
      next_cycle();
      wr_strb = '0;
   endtask

   task automatic request_read(input int row);
      rd_addr = addr_tab[row];
      rd_en   = 1'b1;
      @(negedge s_axi_aclk);
      while (!rd_cmd_rdy) @(negedge s_axi_aclk);
      exp_rd.push_back({exp_tab[row][2:0], addr_tab[row][`APP_ADDR_LSB +: `APP_ADDR_W],
                        {`MEM_DATA_W{1'b0}}, {`MEM_STRB_W{1'b0}}});
      next_cycle();
      rd_en = 1'b0;
   endtask

   task automatic wait_drained();
      while (got_wr.size() < exp_wr.size() || got_rd.size() < exp_rd.size()) begin
         @(negedge s_axi_aclk);
      end
   endtask

   // Data bit 0 set holds app_rdy low, clear releases it and drains
   task automatic stall_memory(input int row);
      app_rdy = !data_tab[row][0];
      @(negedge s_axi_aclk);
      if (app_rdy) begin
         wait_drained();
      end
      compare_values($sformatf("row %0d wr_cmd_rdy", row), exp_tab[row], wr_cmd_rdy);
      next_cycle();
   endtask

   ////////////////////
   // Main sequence
   ////////////////////
   initial begin
      s_axi_aresetn = 1'b0;
      awaddr        = '0;
      awvalid       = 1'b0;
      wdata         = '0;
      wvalid        = 1'b0;
      bready        = 1'b1;
      araddr        = '0;
      arvalid       = 1'b0;
      rready        = 1'b1;
      wr_addr       = '0;
      wr_data       = '0;
      wr_strb       = '0;
      rd_en         = 1'b0;
      rd_addr       = '0;
      app_rdy       = 1'b1;
      num_rows      = 0;
      timeout_limit = 0;
      seed          = 32'hffac;

      add_row(OP_LITE_WR, 32'h0, 64'hf000_0001, '0, '0);
      add_row(OP_LITE_WR, 32'h4, 64'h1000_0003, '0, '0);
      add_row(OP_LITE_RD, 32'h0, '0, '0, 32'hf000_0001);
      add_row(OP_LITE_RD, 32'h4, '0, '0, 32'h1000_0003);
      // Wrapped sum
      add_row(OP_LITE_RD, 32'h8, '0, '0, 32'h0000_0004);
      add_row(OP_LITE_RD, 32'hc, '0, '0, 32'h0);
      add_row(OP_LITE_RD, 32'h40, '0, '0, 32'h0);
      add_row(OP_MEM_WR, 32'h0000_1238, {$random(seed), $random(seed)}, 8'hff,
              mem_bridge_pkg::WRITE);
      add_row(OP_MEM_WR, 32'h8765_4320, {$random(seed), $random(seed)}, 8'h0f,
              mem_bridge_pkg::WRITE_MASKED);
      add_row(OP_MEM_WR, 32'h0000_0100, {$random(seed), $random(seed)}, 8'h00, '0);
      add_row(OP_MEM_RD, 32'h0000_2000, '0, '0, mem_bridge_pkg::READ);
      add_row(OP_MEM_RD, 32'h0000_3008, '0, '0, mem_bridge_pkg::READ);
      add_row(OP_MEM_RD, 32'hffff_fff8, '0, '0, mem_bridge_pkg::READ);
      add_row(OP_STALL, '0, 64'h1, '0, 32'h1);
      add_row(OP_MEM_WR, 32'h0001_0000, {$random(seed), $random(seed)}, 8'hff,
              mem_bridge_pkg::WRITE);
      add_row(OP_MEM_WR, 32'h0001_0008, {$random(seed), $random(seed)}, 8'ha5,
              mem_bridge_pkg::WRITE_MASKED);
      add_row(OP_MEM_WR, 32'h0001_0010, {$random(seed), $random(seed)}, 8'hff,
              mem_bridge_pkg::WRITE);
      add_row(OP_MEM_WR, 32'h0001_0018, {$random(seed), $random(seed)}, 8'h80,
              mem_bridge_pkg::WRITE_MASKED);
      add_row(OP_STALL, '0, 64'h1, '0, 32'h0);
      add_row(OP_STALL, '0, 64'h0, '0, 32'h1);
      add_row(OP_MEM_RD, 32'h00ab_cd40, '0, '0, mem_bridge_pkg::READ);

      timeout_limit = 16 + 40 * num_rows;

      repeat (16) @(posedge s_axi_aclk);
      #1;
      s_axi_aresetn = 1'b1;
      next_cycle();

      for (int i = 0; i < num_rows; i++) begin
         case (op_tab[i])
            OP_LITE_WR: axi_write(i);
            OP_LITE_RD: axi_read(i);
            OP_MEM_WR:  request_write(i);
            OP_MEM_RD:  request_read(i);
            default:    stall_memory(i);
         endcase
      end

      app_rdy = 1'b1;
      wait_drained();
      // A few idle cycles so that any extra command would show up
      repeat (4) next_cycle();

      compare_values("write command count", exp_wr.size(), got_wr.size());
      compare_values("read command count", exp_rd.size(), got_rd.size());
      for (int k = 0; k < exp_wr.size(); k++) begin
         compare_values($sformatf("write command %0d", k), exp_wr[k], got_wr[k]);
      end
      for (int k = 0; k < exp_rd.size(); k++) begin
         compare_values($sformatf("read command %0d", k), exp_rd[k], got_rd[k]);
      end

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== verif/mem_bridge_asserts.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module mem_bridge_asserts (
   input logic                   s_axi_aclk,
   input logic                   s_axi_aresetn,
   input logic                   app_rdy,
   input logic                   app_en,
   input logic [2:0]             app_cmd,
   input logic [`APP_ADDR_W-1:0] app_addr,
   input logic [`MEM_DATA_W-1:0] app_wdf_data,
   input logic [`MEM_STRB_W-1:0] app_wdf_mask,
   input logic                   s_axi_lite_bvalid,
   input logic                   s_axi_lite_bready,
   input logic                   s_axi_lite_awready
);

   int assert_fail_cnt = 0;

   ////////////////////
   // Memory command port
   ////////////////////
   property app_hold_p;
      @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      (app_en && !app_rdy) |=> (app_en && $stable(app_cmd) && $stable(app_addr)
                                && $stable(app_wdf_data) && $stable(app_wdf_mask));
   endproperty

   app_hold_a: assert property (app_hold_p)
      else begin
         $error("app_en or command fields changed while app_rdy was low");
         assert_fail_cnt++;
      end

   ////////////////////
   // AXI-lite write
   ////////////////////
   property bvalid_hold_p;
      @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      (s_axi_lite_bvalid && !s_axi_lite_bready) |=> s_axi_lite_bvalid;
   endproperty

   bvalid_hold_a: assert property (bvalid_hold_p)
      else begin
         $error("bvalid dropped before bready");
         assert_fail_cnt++;
      end

   // Ready is a single-cycle pulse
   property awready_pulse_p;
      @(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_lite_awready |=> !s_axi_lite_awready;
   endproperty

   awready_pulse_a: assert property (awready_pulse_p)
      else begin
         $error("awready high on two consecutive cycles");
         assert_fail_cnt++;
      end

endmodule

bind mem_bridge_top mem_bridge_asserts asserts_i (
   .s_axi_aclk         (s_axi_aclk),
   .s_axi_aresetn      (s_axi_aresetn),
   .app_rdy            (app_rdy),
   .app_en             (app_en),
   .app_cmd            (app_cmd),
   .app_addr           (app_addr),
   .app_wdf_data       (app_wdf_data),
   .app_wdf_mask       (app_wdf_mask),
   .s_axi_lite_bvalid  (s_axi_lite_bvalid),
   .s_axi_lite_bready  (s_axi_lite_bready),
   .s_axi_lite_awready (s_axi_lite_awready)
);

// ==== rtl/mem_bridge_top.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module mem_bridge_top (
   input  logic                    s_axi_aclk,
   input  logic                    s_axi_aresetn,
   // AXI-lite register port
   input  logic [`LITE_ADDR_W-1:0] s_axi_lite_awaddr,
   input  logic                    s_axi_lite_awvalid,
   output logic                    s_axi_lite_awready,
   input  logic [`LITE_DATA_W-1:0] s_axi_lite_wdata,
   input  logic                    s_axi_lite_wvalid,
   output logic                    s_axi_lite_wready,
   input  logic                    s_axi_lite_bready,
   output logic                    s_axi_lite_bvalid,
   output logic [1:0]              s_axi_lite_bresp,
   input  logic [`LITE_ADDR_W-1:0] s_axi_lite_araddr,
   input  logic                    s_axi_lite_arvalid,
   output logic                    s_axi_lite_arready,
   input  logic                    s_axi_lite_rready,
   output logic                    s_axi_lite_rvalid,
   output logic [`LITE_DATA_W-1:0] s_axi_lite_rdata,
   output logic [1:0]              s_axi_lite_rresp,
   // Memory requests
   input  logic [`REQ_ADDR_W-1:0]  wr_addr,
   input  logic [`MEM_DATA_W-1:0]  wr_data,
   input  logic [`MEM_STRB_W-1:0]  wr_strb,
   output logic                    wr_cmd_rdy,
   input  logic                    rd_en,
   input  logic [`REQ_ADDR_W-1:0]  rd_addr,
   output logic                    rd_cmd_rdy,
   // Memory command port
   input  logic                    app_rdy,
   output logic                    app_en,
   output logic [2:0]              app_cmd,
   output logic [`APP_ADDR_W-1:0]  app_addr,
   output logic [`MEM_DATA_W-1:0]  app_wdf_data,
   output logic [`MEM_STRB_W-1:0]  app_wdf_mask
);

   localparam int NUM_CMD_Q = 2;

   reg_access_if regs_if ();

   // Index 0 carries writes, index 1 reads
   queue_if #(.WORD_W(`CMD_W)) cmd_q [NUM_CMD_Q] ();
   queue_if #(.WORD_W(`MEM_DATA_W + `MEM_STRB_W)) data_q ();

   ////////////////////
   // Register block
   ////////////////////
   axi_lite_slave u_axi_lite_slave (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .awaddr        (s_axi_lite_awaddr),
      .awvalid       (s_axi_lite_awvalid),
      .wdata         (s_axi_lite_wdata),
      .wvalid        (s_axi_lite_wvalid),
      .bready        (s_axi_lite_bready),
      .araddr        (s_axi_lite_araddr),
      .arvalid       (s_axi_lite_arvalid),
      .rready        (s_axi_lite_rready),
      .awready       (s_axi_lite_awready),
      .wready        (s_axi_lite_wready),
      .bvalid        (s_axi_lite_bvalid),
      .bresp         (s_axi_lite_bresp),
      .arready       (s_axi_lite_arready),
      .rvalid        (s_axi_lite_rvalid),
      .rdata         (s_axi_lite_rdata),
      .rresp         (s_axi_lite_rresp),
      .regs          (regs_if)
   );

   test_reg_file u_test_reg_file (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .regs          (regs_if)
   );

   ////////////////////
   // Memory bridge
   ////////////////////
   mem_req_splitter u_mem_req_splitter (
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .wr_strb    (wr_strb),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .wr_cmd_rdy (wr_cmd_rdy),
      .rd_cmd_rdy (rd_cmd_rdy),
      .wq         (cmd_q[0]),
      .rq         (cmd_q[1]),
      .dq         (data_q)
   );

   for (genvar i = 0; i < NUM_CMD_Q; i++) begin : gen_cmd_q
      fwft_queue #(
         .WORD_W (`CMD_W),
         .DEPTH  (`QUEUE_DEPTH)
      ) u_cmd_queue (
         .s_axi_aclk    (s_axi_aclk),
         .s_axi_aresetn (s_axi_aresetn),
         .q             (cmd_q[i])
      );
   end

   fwft_queue #(
      .WORD_W (`MEM_DATA_W + `MEM_STRB_W),
      .DEPTH  (`QUEUE_DEPTH)
   ) u_data_queue (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .q             (data_q)
   );

   mem_cmd_arbiter u_mem_cmd_arbiter (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .wq            (cmd_q[0]),
      .rq            (cmd_q[1]),
      .dq            (data_q),
      .app_rdy       (app_rdy),
      .app_en        (app_en),
      .app_cmd       (app_cmd),
      .app_addr      (app_addr),
      .app_wdf_data  (app_wdf_data),
      .app_wdf_mask  (app_wdf_mask)
   );

endmodule

// ==== rtl/mem_cmd_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module mem_cmd_arbiter (
   input  logic                     s_axi_aclk,
   input  logic                     s_axi_aresetn,
   queue_if.consumer                wq,
   queue_if.consumer                rq,
   queue_if.consumer                dq,
   input  logic                     app_rdy,
   output logic                     app_en,
   output mem_bridge_pkg::app_cmd_e app_cmd,
   output logic [`APP_ADDR_W-1:0]   app_addr,
   output logic [`MEM_DATA_W-1:0]   app_wdf_data,
   output logic [`MEM_STRB_W-1:0]   app_wdf_mask
);

   mem_bridge_pkg::arb_phase_e phase_r;
   logic                       in_write;
   logic                       take;
   logic [`CMD_W-1:0]          head;

   // Phase sticks while its own queue still has work
   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         phase_r <= mem_bridge_pkg::WRITE_PHASE;
      end else begin
         case (phase_r)
            mem_bridge_pkg::WRITE_PHASE: begin
               if (!wq.valid) begin
                  phase_r <= mem_bridge_pkg::READ_PHASE;
               end
            end
            default: begin
               if (!rq.valid) begin
                  phase_r <= mem_bridge_pkg::WRITE_PHASE;
               end
            end
         endcase
      end
   end

   assign in_write = (phase_r == mem_bridge_pkg::WRITE_PHASE);
   assign head     = in_write ? wq.word : rq.word;
   assign app_en   = in_write ? wq.valid : rq.valid;
   assign take     = app_en && app_rdy;

   // Data entry was pushed with its command, so it pops alongside
   assign wq.pop = take && in_write;
   assign dq.pop = take && in_write;
   assign rq.pop = take && !in_write;

   assign app_addr = head[`APP_ADDR_LSB +: `APP_ADDR_W];

   always_comb begin
      if (!in_write) begin
         app_cmd = mem_bridge_pkg::READ;
      end else if (head[`CMD_W-1]) begin
         app_cmd = mem_bridge_pkg::WRITE_MASKED;
      end else begin
         app_cmd = mem_bridge_pkg::WRITE;
      end
   end

   assign app_wdf_data = in_write ? dq.word[`MEM_DATA_W-1:0] : '0;
   assign app_wdf_mask = in_write ? dq.word[`MEM_DATA_W +: `MEM_STRB_W] : '0;

endmodule

// ==== rtl/mem_req_splitter.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module mem_req_splitter (
   input  logic [`REQ_ADDR_W-1:0] wr_addr,
   input  logic [`MEM_DATA_W-1:0] wr_data,
   input  logic [`MEM_STRB_W-1:0] wr_strb,
   input  logic                   rd_en,
   input  logic [`REQ_ADDR_W-1:0] rd_addr,
   output logic                   wr_cmd_rdy,
   output logic                   rd_cmd_rdy,
   queue_if.producer              wq,
   queue_if.producer              rq,
   queue_if.producer              dq
);

   logic wr_accept;
   logic wr_masked;

   // Command and data queues must both have room
   assign wr_cmd_rdy = !wq.full && !dq.full;
   assign rd_cmd_rdy = !rq.full;

   ////////////////////
   // Write requests
   ////////////////////
   // All-zero strobe means no write at all
   assign wr_accept = wr_cmd_rdy && (wr_strb != '0);
   assign wr_masked = (wr_strb != '1);

   assign wq.push      = wr_accept;
   assign wq.push_word = {wr_masked, wr_addr};

   // Memory mask is active high, so the strobe goes in inverted
   assign dq.push      = wr_accept;
   assign dq.push_word = {~wr_strb, wr_data};

   ////////////////////
   // Read requests
   ////////////////////
   assign rq.push      = rd_en && rd_cmd_rdy;
   assign rq.push_word = {1'b0, rd_addr};

endmodule

// ==== rtl/fwft_queue.sv ====
`timescale 1ns/1ps

module fwft_queue #(
   parameter int WORD_W = 8,
   parameter int DEPTH  = 4
) (
   input  logic        s_axi_aclk,
   input  logic        s_axi_aresetn,
   queue_if.queue_side q
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WORD_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic              do_push;
   logic              do_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign q.full  = (count == CNT_W'(DEPTH));
   assign q.valid = (count != '0);
   assign q.word  = mem[rd_ptr];

   // Push while full is dropped
   assign do_push = q.push && !q.full;
   assign do_pop  = q.pop && q.valid;

   always_ff @(posedge s_axi_aclk) begin
      if (do_push) begin
         mem[wr_ptr] <= q.push_word;
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== rtl/test_reg_file.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module test_reg_file (
   input  logic       s_axi_aclk,
   input  logic       s_axi_aresetn,
   reg_access_if.regs regs
);

   logic [`LITE_DATA_W-1:0]  reg1_r;
   logic [`LITE_DATA_W-1:0]  reg2_r;
   logic [`LITE_DATA_W-1:0]  reg3_r;
   mem_bridge_pkg::reg_sel_e wr_sel;
   mem_bridge_pkg::reg_sel_e rd_sel;

   function automatic mem_bridge_pkg::reg_sel_e decode(input logic [`LITE_ADDR_W-1:0] addr);
      case (addr)
         `REG1_ADDR: return mem_bridge_pkg::REG1;
         `REG2_ADDR: return mem_bridge_pkg::REG2;
         `REG3_ADDR: return mem_bridge_pkg::REG3;
         default:    return mem_bridge_pkg::NONE;
      endcase
   endfunction

   assign wr_sel = decode(regs.wr_addr);
   assign rd_sel = decode(regs.rd_addr);

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         reg1_r <= '0;
         reg2_r <= '0;
      end else if (regs.wr_en) begin
         if (wr_sel == mem_bridge_pkg::REG1) begin
            reg1_r <= regs.wr_data;
         end
         if (wr_sel == mem_bridge_pkg::REG2) begin
            reg2_r <= regs.wr_data;
         end
      end
   end

   // Sum lags the operands by one cycle
   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         reg3_r <= '0;
      end else begin
         reg3_r <= reg1_r + reg2_r;
      end
   end

   always_comb begin
      case (rd_sel)
         mem_bridge_pkg::REG1: regs.rd_data = reg1_r;
         mem_bridge_pkg::REG2: regs.rd_data = reg2_r;
         mem_bridge_pkg::REG3: regs.rd_data = reg3_r;
         default:              regs.rd_data = '0;
      endcase
   end

endmodule

// ==== rtl/axi_lite_slave.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

module axi_lite_slave (
   input  logic                    s_axi_aclk,
   input  logic                    s_axi_aresetn,
   input  logic [`LITE_ADDR_W-1:0] awaddr,
   input  logic                    awvalid,
   input  logic [`LITE_DATA_W-1:0] wdata,
   input  logic                    wvalid,
   input  logic                    bready,
   input  logic [`LITE_ADDR_W-1:0] araddr,
   input  logic                    arvalid,
   input  logic                    rready,
   output logic                    awready,
   output logic                    wready,
   output logic                    bvalid,
   output logic [1:0]              bresp,
   output logic                    arready,
   output logic                    rvalid,
   output logic [`LITE_DATA_W-1:0] rdata,
   output logic [1:0]              rresp,
   reg_access_if.master            regs
);

   logic                    w_rdy_r;
   logic                    b_vld_r;
   logic                    r_vld_r;
   logic [`LITE_DATA_W-1:0] r_data_r;
   logic                    wr_accept;

   ////////////////////
   // Write channel
   ////////////////////
   assign wr_accept = w_rdy_r && awvalid && wvalid;

   assign awready = w_rdy_r;
   assign wready  = w_rdy_r;
   assign bvalid  = b_vld_r;
   assign bresp   = mem_bridge_pkg::OKAY;

   // One-cycle ready pulse, held off while a response is pending
   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         w_rdy_r <= 1'b0;
      end else if (w_rdy_r) begin
         w_rdy_r <= 1'b0;
      end else if (!b_vld_r && awvalid && wvalid) begin
         w_rdy_r <= 1'b1;
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         b_vld_r <= 1'b0;
      end else if (b_vld_r && bready) begin
         b_vld_r <= 1'b0;
      end else if (wr_accept) begin
         b_vld_r <= 1'b1;
      end
   end

   assign regs.wr_en   = wr_accept;
   assign regs.wr_addr = awaddr;
   assign regs.wr_data = wdata;

   ////////////////////
   // Read channel
   ////////////////////
   assign arready      = 1'b1;
   assign rvalid       = r_vld_r;
   assign rdata        = r_data_r;
   assign rresp        = mem_bridge_pkg::OKAY;
   assign regs.rd_addr = araddr;

   always_ff @(posedge s_axi_aclk) begin
      if (!s_axi_aresetn) begin
         r_vld_r <= 1'b0;
      end else begin
         r_vld_r <= arvalid || (r_vld_r && !rready);
      end
   end

   always_ff @(posedge s_axi_aclk) begin
      if (arvalid) begin
         r_data_r <= regs.rd_data;
      end
   end

endmodule

// ==== rtl/bridge_ifs.sv ====
`timescale 1ns/1ps
`include "mem_bridge_defines.svh"

// Push side, FWFT head and pop of one queue
interface queue_if #(
   parameter int WORD_W = 8
);
   logic              push;
   logic [WORD_W-1:0] push_word;
   logic              full;
   logic              valid;
   logic [WORD_W-1:0] word;
   logic              pop;

   modport producer (
      output push,
      output push_word,
      input  full
   );

   modport queue_side (
      input  push,
      input  push_word,
      input  pop,
      output full,
      output valid,
      output word
   );

   modport consumer (
      input  valid,
      input  word,
      output pop
   );
endinterface

// Register access between the AXI-lite slave and the register file
interface reg_access_if;
   logic                    wr_en;
   logic [`LITE_ADDR_W-1:0] wr_addr;
   logic [`LITE_DATA_W-1:0] wr_data;
   logic [`LITE_ADDR_W-1:0] rd_addr;
   logic [`LITE_DATA_W-1:0] rd_data;

   modport master (output wr_en, output wr_addr, output wr_data, output rd_addr, input rd_data);
   modport regs (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);
endinterface

// ==== rtl/mem_bridge_pkg.sv ====
package mem_bridge_pkg;

   // Memory command codes
   typedef enum logic [2:0] {
      WRITE        = 3'b000,
      READ         = 3'b001,
      WRITE_MASKED = 3'b011
   } app_cmd_e;

   typedef enum logic {
      WRITE_PHASE = 1'b0,
      READ_PHASE  = 1'b1
   } arb_phase_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   typedef enum logic [1:0] {
      REG1,
      REG2,
      REG3,
      NONE
   } reg_sel_e;

endpackage

// ==== rtl/mem_bridge_defines.svh ====
`ifndef MEM_BRIDGE_DEFINES_SVH
`define MEM_BRIDGE_DEFINES_SVH

////////////////////
// Memory request side
////////////////////
`define REQ_ADDR_W   32
`define APP_ADDR_W   28
`define APP_ADDR_LSB 3
`define MEM_DATA_W   64
`define MEM_STRB_W   8

// Request address plus masked-write flag on top
`define CMD_W        (`REQ_ADDR_W + 1)
`define QUEUE_DEPTH  4

////////////////////
// AXI-lite register block
////////////////////
`define LITE_ADDR_W  16
`define LITE_DATA_W  32
`define REG1_ADDR    16'h0000
`define REG2_ADDR    16'h0004
`define REG3_ADDR    16'h0008

`endif
